// ==== verilog/dcc_consts.svh ====
`ifndef DCC_CONSTS_SVH
`define DCC_CONSTS_SVH

// ==============================
// dcc widths and sizes
// ==============================

// cpu side byte address
`define DCC_ADDR_W 32

// one bus word, half of a cpu data item
`define DCC_HALF_W 32

// byte enables per bus word
`define DCC_HALF_SEL_W 4

// request queue entries
`define DCC_DEPTH 4

// bus transaction counter, value 0 is never handed out
`define DCC_TRAN_W 4

// channel number in the upper bits of every bus id
`define DCC_CHANNEL 3'd1

`endif

// ==== verilog/dcc_pkg.sv ====
`include "dcc_consts.svh"

package dcc_pkg;

	// ==============================
	// address and data
	// ==============================
	typedef logic [`DCC_ADDR_W-1:0] addr_t;
	typedef logic [`DCC_HALF_W-1:0] half_data_t;
	// cpu data item is two bus words, lower word first
	typedef logic [2*`DCC_HALF_W-1:0] line_data_t;
	typedef logic [`DCC_HALF_SEL_W-1:0] half_sel_t;
	typedef logic [2*`DCC_HALF_SEL_W-1:0] line_sel_t;

	// ==============================
	// ids and indices
	// ==============================
	typedef logic [3:0] cpu_tid_t;
	// channel in the upper bits, transaction counter below
	typedef logic [$bits(`DCC_CHANNEL)+`DCC_TRAN_W-1:0] bus_tid_t;
	typedef logic [$clog2(`DCC_DEPTH)-1:0] entry_idx_t;

	// sequencer states
	typedef enum logic [1:0] {
		IDLE,
		SPLIT_LO,
		SPLIT_HI,
		POST
	} split_state_t;

endpackage

// ==== verilog/dcc_ifs.sv ====
`timescale 1ns/10ps
`include "dcc_consts.svh"

// queue offers the request to split, splitter writes the records back
interface dcc_split_if import dcc_pkg::*; ();
	logic       pick_v;
	entry_idx_t pick_idx;
	addr_t      pick_adr;
	line_sel_t  pick_sel;
	line_data_t pick_dat;
	logic       pick_we;
	// one record per strobe, half 1 closes the split
	logic       tr_wr;
	logic       tr_half;
	bus_tid_t   tr_tid;
	logic       tr_skip;

	modport queue (output pick_v, pick_idx, pick_adr, pick_sel, pick_dat, pick_we,
		input tr_wr, tr_half, tr_tid, tr_skip);
	modport split (input pick_v, pick_idx, pick_adr, pick_sel, pick_dat, pick_we,
		output tr_wr, tr_half, tr_tid, tr_skip);
endinterface

// lowest pending bus transaction, taken by the bus request register
interface dcc_issue_if import dcc_pkg::*; ();
	logic       pend_v;
	entry_idx_t pend_idx;
	logic       pend_half;
	addr_t      pend_adr;
	half_data_t pend_dat;
	half_sel_t  pend_sel;
	logic       pend_we;
	bus_tid_t   pend_tid;
	logic       take;

	modport queue (output pend_v, pend_idx, pend_half, pend_adr, pend_dat, pend_sel,
		pend_we, pend_tid, input take);
	modport issue (input pend_v, pend_idx, pend_half, pend_adr, pend_dat, pend_sel,
		pend_we, pend_tid, output take);
endinterface

// bus ack match and completed entry, both from the queue
interface dcc_resp_if import dcc_pkg::*; ();
	logic       hit;
	entry_idx_t hit_idx;
	logic       hit_half;
	logic       cmpl;
	entry_idx_t cmpl_idx;
	cpu_tid_t   cmpl_tid;

	modport queue (output hit, hit_idx, hit_half, cmpl, cmpl_idx, cmpl_tid);
	modport collect (input hit, hit_idx, hit_half, cmpl, cmpl_idx, cmpl_tid);
endinterface

// ==== verilog/dcc_req_queue.sv ====
`timescale 1ns/10ps
`include "dcc_consts.svh"

module dcc_req_queue
	import dcc_pkg::*;
(
	input  logic       clk_i,
	input  logic       rst_i,
	input  logic       cpu_req_i,
	input  logic       cpu_we_i,
	input  addr_t      cpu_adr_i,
	input  line_sel_t  cpu_sel_i,
	input  line_data_t cpu_dat_i,
	input  cpu_tid_t   cpu_tid_i,
	output logic       cpu_busy_o,
	input  logic       bus_ack_i,
	input  bus_tid_t   bus_tid_i,
	dcc_split_if.queue split,
	dcc_issue_if.queue issue,
	dcc_resp_if.queue  resp
);

// ==============================
// entry storage
// ==============================
logic [`DCC_DEPTH-1:0] ent_v;
logic [`DCC_DEPTH-1:0] ent_we;
logic [`DCC_DEPTH-1:0] ent_split;
addr_t      ent_adr [`DCC_DEPTH];
line_sel_t  ent_sel [`DCC_DEPTH];
line_data_t ent_dat [`DCC_DEPTH];
cpu_tid_t   ent_tid [`DCC_DEPTH];
// per half: bus id, waiting for issue, read out on bus, finished
bus_tid_t   ent_btid [`DCC_DEPTH][2];
logic [1:0] ent_pend [`DCC_DEPTH];
logic [1:0] ent_out [`DCC_DEPTH];
logic [1:0] ent_done [`DCC_DEPTH];

// entry under split, held so a late arrival in a lower slot cannot steal the pick
logic       lock_v;
entry_idx_t lock_idx;

logic       free_v;
entry_idx_t free_idx;
logic       dup;
logic       cand_v;
entry_idx_t cand_idx;
logic       hit_v;
logic       accept;

// ==============================
// entry search
// ==============================
// scan from the top so the lowest index wins
always_comb begin
	free_v = 1'b0;
	free_idx = '0;
	dup = 1'b0;
	cand_v = 1'b0;
	cand_idx = '0;
	resp.cmpl = 1'b0;
	resp.cmpl_idx = '0;
	for (int i = `DCC_DEPTH-1; i >= 0; i--) begin
		if (!ent_v[i]) begin
			free_v = 1'b1;
			free_idx = entry_idx_t'(i);
		end
		if (ent_v[i] && ent_tid[i] == cpu_tid_i)
			dup = 1'b1;
		if (ent_v[i] && !ent_split[i]) begin
			cand_v = 1'b1;
			cand_idx = entry_idx_t'(i);
		end
		if (ent_v[i] && ent_done[i] == 2'b11) begin
			resp.cmpl = 1'b1;
			resp.cmpl_idx = entry_idx_t'(i);
		end
	end
end

// pending transaction to issue and bus ack match, per half
always_comb begin
	issue.pend_v = 1'b0;
	issue.pend_idx = '0;
	issue.pend_half = 1'b0;
	hit_v = 1'b0;
	resp.hit_idx = '0;
	resp.hit_half = 1'b0;
	for (int i = `DCC_DEPTH-1; i >= 0; i--) begin
		for (int h = 1; h >= 0; h--) begin
			if (ent_v[i] && ent_pend[i][h]) begin
				issue.pend_v = 1'b1;
				issue.pend_idx = entry_idx_t'(i);
				issue.pend_half = h[0];
			end
			if (ent_v[i] && ent_out[i][h] && ent_btid[i][h] == bus_tid_i) begin
				hit_v = 1'b1;
				resp.hit_idx = entry_idx_t'(i);
				resp.hit_half = h[0];
			end
		end
	end
end

// no free slot means busy, a duplicate id is silently ignored
assign cpu_busy_o = !free_v;
assign accept = cpu_req_i && free_v && !dup;

assign split.pick_v = lock_v;
assign split.pick_idx = lock_idx;
assign split.pick_adr = ent_adr[lock_idx];
assign split.pick_sel = ent_sel[lock_idx];
assign split.pick_dat = ent_dat[lock_idx];
assign split.pick_we = ent_we[lock_idx];

// slice the chosen half out of the request
assign issue.pend_adr = ent_adr[issue.pend_idx];
assign issue.pend_we = ent_we[issue.pend_idx];
assign issue.pend_tid = ent_btid[issue.pend_idx][issue.pend_half];
assign issue.pend_dat = ent_dat[issue.pend_idx][issue.pend_half*`DCC_HALF_W +: `DCC_HALF_W];
assign issue.pend_sel =
	ent_sel[issue.pend_idx][issue.pend_half*`DCC_HALF_SEL_W +: `DCC_HALF_SEL_W];

assign resp.hit = bus_ack_i && hit_v;
assign resp.cmpl_tid = ent_tid[resp.cmpl_idx];

// ==============================
// entry state
// ==============================
always_ff @(posedge clk_i) begin
	if (rst_i) begin
		ent_v <= '0;
		ent_split <= '0;
		lock_v <= 1'b0;
		for (int i = 0; i < `DCC_DEPTH; i++) begin
			ent_pend[i] <= 2'b00;
			ent_out[i] <= 2'b00;
			ent_done[i] <= 2'b00;
		end
	end
	else begin
		if (accept) begin
			ent_v[free_idx] <= 1'b1;
			ent_split[free_idx] <= 1'b0;
			ent_pend[free_idx] <= 2'b00;
			ent_out[free_idx] <= 2'b00;
			ent_done[free_idx] <= 2'b00;
		end
		// grab the next request to split
		if (!lock_v && cand_v) begin
			lock_v <= 1'b1;
			lock_idx <= cand_idx;
		end
		// empty half is done at once, otherwise it waits for issue
		if (split.tr_wr) begin
			if (split.tr_skip)
				ent_done[lock_idx][split.tr_half] <= 1'b1;
			else
				ent_pend[lock_idx][split.tr_half] <= 1'b1;
			if (split.tr_half) begin
				ent_split[lock_idx] <= 1'b1;
				lock_v <= 1'b0;
			end
		end
		// writes are finished once issued, reads wait for the ack
		if (issue.take) begin
			ent_pend[issue.pend_idx][issue.pend_half] <= 1'b0;
			if (ent_we[issue.pend_idx])
				ent_done[issue.pend_idx][issue.pend_half] <= 1'b1;
			else
				ent_out[issue.pend_idx][issue.pend_half] <= 1'b1;
		end
		if (resp.hit) begin
			ent_out[resp.hit_idx][resp.hit_half] <= 1'b0;
			ent_done[resp.hit_idx][resp.hit_half] <= 1'b1;
		end
		// freed on the edge that registers the cpu ack
		if (resp.cmpl)
			ent_v[resp.cmpl_idx] <= 1'b0;
	end
end

// request payload and bus ids
always_ff @(posedge clk_i) begin
	if (accept) begin
		ent_we[free_idx] <= cpu_we_i;
		ent_adr[free_idx] <= cpu_adr_i;
		ent_sel[free_idx] <= cpu_sel_i;
		ent_dat[free_idx] <= cpu_dat_i;
		ent_tid[free_idx] <= cpu_tid_i;
	end
	if (split.tr_wr && !split.tr_skip)
		ent_btid[lock_idx][split.tr_half] <= split.tr_tid;
end

endmodule

// ==== verilog/dcc_splitter.sv ====
`timescale 1ns/10ps
`include "dcc_consts.svh"

module dcc_splitter
	import dcc_pkg::*;
(
	input logic        clk_i,
	input logic        rst_i,
	dcc_split_if.split split
);

split_state_t state;
// transaction counter, runs 1..15 and never hands out 0
logic [`DCC_TRAN_W-1:0] tcnt;
half_sel_t half_sel;

// ==============================
// record outputs
// ==============================
// one record in each split state, lower half first
assign split.tr_wr = (state == SPLIT_LO) || (state == SPLIT_HI);
assign split.tr_half = (state == SPLIT_HI);

assign half_sel = split.tr_half ? split.pick_sel[2*`DCC_HALF_SEL_W-1:`DCC_HALF_SEL_W]
	: split.pick_sel[`DCC_HALF_SEL_W-1:0];

// nothing selected in this half, so no bus transaction for it
assign split.tr_skip = ~|half_sel;
assign split.tr_tid = {`DCC_CHANNEL, tcnt};

// ==============================
// sequencer
// ==============================
always_ff @(posedge clk_i) begin
	if (rst_i) begin
		state <= IDLE;
		tcnt <= `DCC_TRAN_W'(1);
	end
	else begin
		case (state)
		IDLE:
			if (split.pick_v)
				state <= SPLIT_LO;
		SPLIT_LO:
			state <= SPLIT_HI;
		SPLIT_HI:
			state <= POST;
		// POST gives the queue a cycle to lock the next pick
		default:
			state <= IDLE;
		endcase
		// only a real transaction uses up a bus id
		if (split.tr_wr && !split.tr_skip) begin
			if (&tcnt)
				tcnt <= `DCC_TRAN_W'(1);
			else
				tcnt <= tcnt + 1'b1;
		end
	end
end

endmodule

// ==== verilog/dcc_bus_issue.sv ====
`timescale 1ns/10ps
`include "dcc_consts.svh"

module dcc_bus_issue
	import dcc_pkg::*;
(
	input  logic       clk_i,
	input  logic       rst_i,
	input  logic       bus_full_i,
	dcc_issue_if.issue issue,
	output logic       bus_cyc_o,
	output logic       bus_we_o,
	output addr_t      bus_adr_o,
	output half_sel_t  bus_sel_o,
	output half_data_t bus_dat_o,
	output bus_tid_t   bus_tid_o
);

// with full low the register is either empty or drains this cycle,
// with full high it is holding, so full alone decides the take
assign issue.take = issue.pend_v && !bus_full_i;

// ==============================
// bus request register
// ==============================
always_ff @(posedge clk_i) begin
	if (rst_i)
		bus_cyc_o <= 1'b0;
	else if (issue.take)
		bus_cyc_o <= 1'b1;
	else if (!bus_full_i)
		bus_cyc_o <= 1'b0;
end

// 8-byte aligned request address, upper word at +4
always_ff @(posedge clk_i) begin
	if (issue.take) begin
		bus_we_o <= issue.pend_we;
		bus_adr_o <= {issue.pend_adr[`DCC_ADDR_W-1:3], issue.pend_half, 2'b00};
		bus_sel_o <= issue.pend_sel;
		bus_dat_o <= issue.pend_dat;
		bus_tid_o <= issue.pend_tid;
	end
end

endmodule

// ==== verilog/dcc_resp_collect.sv ====
`timescale 1ns/10ps
`include "dcc_consts.svh"

module dcc_resp_collect
	import dcc_pkg::*;
(
	input  logic         clk_i,
	input  logic         rst_i,
	input  half_data_t   bus_dat_i,
	input  logic         bus_err_i,
	dcc_resp_if.collect  resp,
	output logic         cpu_ack_o,
	output cpu_tid_t     cpu_ack_tid_o,
	output line_data_t   cpu_dat_o,
	output logic         cpu_err_o
);

// one line buffer and sticky error per queue entry
line_data_t            line_buf [`DCC_DEPTH];
logic [`DCC_DEPTH-1:0] err_flag;

// ==============================
// assembly
// ==============================
// buffers start at zero so an unread half returns zero
always_ff @(posedge clk_i) begin
	if (rst_i) begin
		cpu_ack_o <= 1'b0;
		err_flag <= '0;
		for (int i = 0; i < `DCC_DEPTH; i++)
			line_buf[i] <= '0;
	end
	else begin
		cpu_ack_o <= resp.cmpl;
		if (resp.hit) begin
			if (resp.hit_half)
				line_buf[resp.hit_idx][2*`DCC_HALF_W-1:`DCC_HALF_W] <= bus_dat_i;
			else
				line_buf[resp.hit_idx][`DCC_HALF_W-1:0] <= bus_dat_i;
			err_flag[resp.hit_idx] <= err_flag[resp.hit_idx] | bus_err_i;
		end
		// a hit never targets the entry that completes in the same cycle
		if (resp.cmpl) begin
			line_buf[resp.cmpl_idx] <= '0;
			err_flag[resp.cmpl_idx] <= 1'b0;
		end
	end
end

// ack payload, valid with cpu_ack_o
always_ff @(posedge clk_i) begin
	if (resp.cmpl) begin
		cpu_ack_tid_o <= resp.cmpl_tid;
		cpu_dat_o <= line_buf[resp.cmpl_idx];
		cpu_err_o <= err_flag[resp.cmpl_idx];
	end
end

endmodule

// ==== verilog/dcc_top.sv ====
`timescale 1ns/10ps
`include "dcc_consts.svh"

module dcc_top
	import dcc_pkg::*;
(
	input  logic       clk_i,
	input  logic       rst_i,
	// cpu request side
	input  logic       cpu_req_i,
	input  logic       cpu_we_i,
	input  addr_t      cpu_adr_i,
	input  line_sel_t  cpu_sel_i,
	input  line_data_t cpu_dat_i,
	input  cpu_tid_t   cpu_tid_i,
	output logic       cpu_busy_o,
	output logic       cpu_ack_o,
	output cpu_tid_t   cpu_ack_tid_o,
	output line_data_t cpu_dat_o,
	output logic       cpu_err_o,
	// bus request side
	output logic       bus_cyc_o,
	output logic       bus_we_o,
	output addr_t      bus_adr_o,
	output half_sel_t  bus_sel_o,
	output half_data_t bus_dat_o,
	output bus_tid_t   bus_tid_o,
	// bus response side
	input  logic       bus_full_i,
	input  logic       bus_ack_i,
	input  bus_tid_t   bus_tid_i,
	input  half_data_t bus_dat_i,
	input  logic       bus_err_i
);

dcc_split_if split_link ();
dcc_issue_if issue_link ();
dcc_resp_if  resp_link ();

dcc_req_queue u_queue (
	.clk_i, .rst_i, .cpu_req_i, .cpu_we_i, .cpu_adr_i, .cpu_sel_i, .cpu_dat_i,
	.cpu_tid_i, .cpu_busy_o, .bus_ack_i, .bus_tid_i,
	.split(split_link), .issue(issue_link), .resp(resp_link)
);

dcc_splitter u_splitter (.clk_i, .rst_i, .split(split_link));

dcc_bus_issue u_issue (
	.clk_i, .rst_i, .bus_full_i, .issue(issue_link),
	.bus_cyc_o, .bus_we_o, .bus_adr_o, .bus_sel_o, .bus_dat_o, .bus_tid_o
);

dcc_resp_collect u_collect (
	.clk_i, .rst_i, .bus_dat_i, .bus_err_i, .resp(resp_link),
	.cpu_ack_o, .cpu_ack_tid_o, .cpu_dat_o, .cpu_err_o
);

endmodule

// ==== sim/dcc_mem_model.sv ====
`timescale 1ns/10ps

module dcc_mem_model
	import dcc_pkg::*;
(
	input  logic       clk_i,
	input  logic       rst_i,
	input  logic       bus_cyc_i,
	input  logic       bus_we_i,
	input  addr_t      bus_adr_i,
	input  half_sel_t  bus_sel_i,
	input  half_data_t bus_dat_i,
	input  bus_tid_t   bus_tid_i,
	output logic       bus_full_o,
	output logic       bus_ack_o,
	output bus_tid_t   bus_tid_o,
	output half_data_t bus_dat_o,
	output logic       bus_err_o
);

integer seed = 32'h58a2;
// only written words are stored, the rest follow the address rule
half_data_t mem [addr_t];
// outstanding reads waiting for their reply
logic       slot_v    [4];
bus_tid_t   slot_tid  [4];
half_data_t slot_dat  [4];
logic       slot_err  [4];
int         slot_wait [4];

function automatic half_data_t read_word(input addr_t a);
	if (mem.exists(a))
		return mem[a];
	return a ^ 32'hA5A5_0000;
endfunction

initial begin
	bus_full_o = 1'b0;
	bus_ack_o = 1'b0;
	bus_tid_o = '0;
	bus_dat_o = '0;
	bus_err_o = 1'b0;
	for (int k = 0; k < 4; k++)
		slot_v[k] = 1'b0;
end

// ==============================
// responder, acts 10 ns after each edge
// ==============================
always begin : serve
	logic       in_rst;
	int         start;
	int         pick;
	int         used;
	int         s;
	half_data_t w;
	@(posedge clk_i);
	in_rst = rst_i;
	#10;
	bus_ack_o = 1'b0;
	if (in_rst) begin
		bus_full_o = 1'b0;
		for (int k = 0; k < 4; k++)
			slot_v[k] = 1'b0;
	end
	else begin
		// one ready read per cycle, search starts at a random slot
		start = $unsigned($random(seed)) % 4;
		pick = -1;
		for (int k = 0; k < 4; k++) begin
			s = (start + k) % 4;
			if (pick < 0 && slot_v[s] && slot_wait[s] == 0)
				pick = s;
		end
		if (pick >= 0) begin
			bus_ack_o = 1'b1;
			bus_tid_o = slot_tid[pick];
			bus_dat_o = slot_dat[pick];
			bus_err_o = slot_err[pick];
			slot_v[pick] = 1'b0;
		end
		used = 0;
		for (int k = 0; k < 4; k++) begin
			if (slot_v[k] && slot_wait[k] > 0)
				slot_wait[k]--;
			if (slot_v[k])
				used++;
		end
		// full at random, and always while every slot is taken
		bus_full_o = ($unsigned($random(seed)) % 4 == 0) || (used == 4);
		// request on the bus with full low is taken this cycle
		if (bus_cyc_i && !bus_full_o) begin
			if (bus_we_i) begin
				w = read_word(bus_adr_i);
				for (int b = 0; b < 4; b++)
					if (bus_sel_i[b])
						w[8*b +: 8] = bus_dat_i[8*b +: 8];
				mem[bus_adr_i] = w;
			end
			else begin
				pick = -1;
				for (int k = 0; k < 4; k++)
					if (pick < 0 && !slot_v[k])
						pick = k;
				slot_v[pick] = 1'b1;
				slot_tid[pick] = bus_tid_i;
				slot_dat[pick] = read_word(bus_adr_i);
				slot_err[pick] = (bus_adr_i >= 32'hF000_0000);
				slot_wait[pick] = $unsigned($random(seed)) % 6;
			end
		end
	end
end

endmodule

// ==== sim/tb_dcc.sv ====
`timescale 1ns/10ps

module tb_dcc
	import dcc_pkg::*;
();

localparam int ROWS = 5;

logic       clk_i;
logic       rst_i;
logic       cpu_req_i;
logic       cpu_we_i;
addr_t      cpu_adr_i;
line_sel_t  cpu_sel_i;
line_data_t cpu_dat_i;
cpu_tid_t   cpu_tid_i;
logic       cpu_busy_o;
logic       cpu_ack_o;
cpu_tid_t   cpu_ack_tid_o;
line_data_t cpu_dat_o;
logic       cpu_err_o;
logic       bus_cyc_o;
logic       bus_we_o;
addr_t      bus_adr_o;
half_sel_t  bus_sel_o;
half_data_t bus_dat_o;
bus_tid_t   bus_tid_o;
logic       bus_full_i;
logic       bus_ack_i;
bus_tid_t   bus_tid_i;
half_data_t bus_dat_i;
logic       bus_err_i;

// stimulus table, one request per row
logic       row_we   [ROWS];
addr_t      row_adr  [ROWS];
line_sel_t  row_sel  [ROWS];
line_data_t row_dat  [ROWS];
cpu_tid_t   row_tid  [ROWS];
line_data_t row_exp  [ROWS];
logic       row_err  [ROWS];
string      row_name [ROWS];

// acknowledges seen, in arrival order
cpu_tid_t   ack_tid_q [$];
line_data_t ack_dat_q [$];
logic       ack_err_q [$];
int bus_xfers = 0;
int errors = 0;
int passed = 0;
int failed = 0;

dcc_top dut (
	.clk_i, .rst_i, .cpu_req_i, .cpu_we_i, .cpu_adr_i, .cpu_sel_i, .cpu_dat_i, .cpu_tid_i,
	.cpu_busy_o, .cpu_ack_o, .cpu_ack_tid_o, .cpu_dat_o, .cpu_err_o,
	.bus_cyc_o, .bus_we_o, .bus_adr_o, .bus_sel_o, .bus_dat_o, .bus_tid_o,
	.bus_full_i, .bus_ack_i, .bus_tid_i, .bus_dat_i, .bus_err_i
);

dcc_mem_model u_mem (
	.clk_i, .rst_i, .bus_cyc_i(bus_cyc_o), .bus_we_i(bus_we_o), .bus_adr_i(bus_adr_o),
	.bus_sel_i(bus_sel_o), .bus_dat_i(bus_dat_o), .bus_tid_i(bus_tid_o),
	.bus_full_o(bus_full_i), .bus_ack_o(bus_ack_i), .bus_tid_o(bus_tid_i),
	.bus_dat_o(bus_dat_i), .bus_err_o(bus_err_i)
);

initial begin
	clk_i = 1'b0;
	forever #50 clk_i = ~clk_i;
end

// mid-cycle monitor, counts bus transfers and logs acknowledges
always @(negedge clk_i) begin
	if (!rst_i && bus_cyc_o && !bus_full_i)
		bus_xfers++;
	if (!rst_i && cpu_ack_o) begin
		ack_tid_q.push_back(cpu_ack_tid_o);
		ack_dat_q.push_back(cpu_dat_o);
		ack_err_q.push_back(cpu_err_o);
	end
end

// ==============================
// expected values
// ==============================
function automatic half_data_t rule_word(input addr_t a);
	return a ^ 32'hA5A5_0000;
endfunction

function automatic line_data_t rule_line(input addr_t a);
	return {rule_word(a + 4), rule_word(a)};
endfunction

// bytes under sel come from new_w
function automatic half_data_t merge_word(input half_data_t old_w, input half_data_t new_w,
	input half_sel_t sel);
	half_data_t w;
	w = old_w;
	for (int b = 0; b < 4; b++)
		if (sel[b])
			w[8*b +: 8] = new_w[8*b +: 8];
	return w;
endfunction

task automatic set_row(input int i, input string name, input logic we, input addr_t adr,
	input line_sel_t sel, input line_data_t dat, input cpu_tid_t tid,
	input line_data_t exp_dat, input logic exp_err);
	row_name[i] = name;
	row_we[i] = we;
	row_adr[i] = adr;
	row_sel[i] = sel;
	row_dat[i] = dat;
	row_tid[i] = tid;
	row_exp[i] = exp_dat;
	row_err[i] = exp_err;
endtask

task automatic load_table();
	set_row(0, "full read", 1'b0, 32'h1000, 8'hFF, '0, 4'd1, rule_line(32'h1000), 1'b0);
	set_row(1, "upper half read", 1'b0, 32'h2008, 8'hF0, '0, 4'd2,
		{rule_word(32'h200C), 32'h0}, 1'b0);
	// a write returns no read data
	set_row(2, "partial write", 1'b1, 32'h3000, 8'h36, 64'h1122_3344_5566_7788, 4'd3,
		'0, 1'b0);
	set_row(3, "read after write", 1'b0, 32'h3000, 8'hFF, '0, 4'd4,
		{merge_word(rule_word(32'h3004), 32'h1122_3344, 4'h3),
		merge_word(rule_word(32'h3000), 32'h5566_7788, 4'h6)}, 1'b0);
	set_row(4, "error address", 1'b0, 32'hF000_0010, 8'hFF, '0, 4'd6,
		rule_line(32'hF000_0010), 1'b1);
endtask

// ==============================
// helpers
// ==============================
task automatic step_clock();
	@(posedge clk_i);
	#10;
endtask

task automatic report_error(input string msg);
	errors++;
	$display("** Error at %0t: %s", $time, msg);
endtask

task automatic report_failure(input string msg);
	errors++;
	$display("%s", msg);
endtask

task automatic drive_req(input logic we, input addr_t adr, input line_sel_t sel,
	input line_data_t dat, input cpu_tid_t tid);
	cpu_req_i = 1'b1;
	cpu_we_i = we;
	cpu_adr_i = adr;
	cpu_sel_i = sel;
	cpu_dat_i = dat;
	cpu_tid_i = tid;
endtask

task automatic clear_acks();
	ack_tid_q.delete();
	ack_dat_q.delete();
	ack_err_q.delete();
endtask

// seen tells whether n acknowledges arrived within limit cycles
task automatic wait_acks(input int n, input int limit, output logic seen);
	int cnt;
	cnt = 0;
	while (ack_tid_q.size() < n && cnt < limit) begin
		step_clock();
		cnt++;
	end
	seen = (ack_tid_q.size() >= n);
endtask

task automatic wait_bus_idle(output logic idle);
	int cnt;
	cnt = 0;
	while (bus_cyc_o && cnt < 100) begin
		step_clock();
		cnt++;
	end
	idle = !bus_cyc_o;
endtask

task automatic close_test(input string name, input int err_before);
	if (errors == err_before) begin
		passed++;
		$display("test %s: ok", name);
	end
	else begin
		failed++;
		$display("test %s: failed", name);
	end
endtask

// ==============================
// tests
// ==============================
task automatic run_row(input int i);
	int err_before;
	int xfer_start;
	int xfer_exp;
	logic ok;
	err_before = errors;
	xfer_start = bus_xfers;
	// one bus transfer per half with a nonzero select
	xfer_exp = int'(|row_sel[i][3:0]) + int'(|row_sel[i][7:4]);
	clear_acks();
	drive_req(row_we[i], row_adr[i], row_sel[i], row_dat[i], row_tid[i]);
	step_clock();
	cpu_req_i = 1'b0;
	wait_acks(1, 200, ok);
	if (!ok)
		report_failure($sformatf("no acknowledge for tid %0d within 200 cycles", row_tid[i]));
	else begin
		if (ack_tid_q[0] !== row_tid[i])
			report_error($sformatf("ack tid %0d, expected %0d", ack_tid_q[0], row_tid[i]));
		if (ack_dat_q[0] !== row_exp[i])
			report_error($sformatf("data %h, expected %h", ack_dat_q[0], row_exp[i]));
		if (ack_err_q[0] !== row_err[i])
			report_error($sformatf("error flag %b, expected %b", ack_err_q[0], row_err[i]));
	end
	wait_bus_idle(ok);
	if (!ok)
		report_failure("bus request still active after 100 cycles");
	if (bus_xfers - xfer_start != xfer_exp)
		report_error($sformatf("%0d bus transfers, expected %0d",
			bus_xfers - xfer_start, xfer_exp));
	close_test(row_name[i], err_before);
endtask

task automatic run_burst();
	int err_before;
	int idx;
	int hits [4];
	logic ok;
	err_before = errors;
	clear_acks();
	for (int k = 0; k < 4; k++) begin
		hits[k] = 0;
		drive_req(1'b0, 32'h4000 + 8*k, 8'hFF, '0, cpu_tid_t'(8 + k));
		step_clock();
	end
	if (cpu_busy_o !== 1'b1)
		report_error("cpu_busy_o low with four requests queued");
	// fifth request offered while busy is dropped
	drive_req(1'b0, 32'h5000, 8'hFF, '0, 4'd12);
	step_clock();
	cpu_req_i = 1'b0;
	wait_acks(4, 400, ok);
	if (!ok)
		report_failure("fewer than four acknowledges within 400 cycles");
	wait_acks(5, 100, ok);
	if (ok)
		report_error("more than four acknowledges for the burst");
	for (int j = 0; j < ack_tid_q.size(); j++) begin
		idx = int'(ack_tid_q[j]) - 8;
		if (idx < 0 || idx > 3)
			report_error($sformatf("unexpected ack tid %0d", ack_tid_q[j]));
		else begin
			hits[idx]++;
			if (ack_dat_q[j] !== rule_line(32'h4000 + 8*idx))
				report_error($sformatf("tid %0d data %h", ack_tid_q[j], ack_dat_q[j]));
			if (ack_err_q[j] !== 1'b0)
				report_error($sformatf("tid %0d error flag set", ack_tid_q[j]));
		end
	end
	for (int k = 0; k < 4; k++)
		if (hits[k] != 1)
			report_error($sformatf("tid %0d acknowledged %0d times", 8 + k, hits[k]));
	close_test("back-to-back reads", err_before);
endtask

task automatic run_duplicate();
	int err_before;
	logic ok;
	err_before = errors;
	clear_acks();
	drive_req(1'b0, 32'h6000, 8'hFF, '0, 4'd5);
	step_clock();
	// same id while the first is still queued
	drive_req(1'b0, 32'h7000, 8'hFF, '0, 4'd5);
	step_clock();
	cpu_req_i = 1'b0;
	wait_acks(1, 200, ok);
	if (!ok)
		report_failure("no acknowledge for tid 5 within 200 cycles");
	wait_acks(2, 100, ok);
	if (ok)
		report_error("duplicate id acknowledged twice");
	if (ack_tid_q.size() > 0 && ack_dat_q[0] !== rule_line(32'h6000))
		report_error($sformatf("tid 5 data %h", ack_dat_q[0]));
	close_test("duplicate id", err_before);
endtask

initial begin
	int err_before;
	rst_i = 1'b1;
	cpu_req_i = 1'b0;
	cpu_we_i = 1'b0;
	cpu_adr_i = '0;
	cpu_sel_i = '0;
	cpu_dat_i = '0;
	cpu_tid_i = '0;
	load_table();
	repeat (3) step_clock();
	rst_i = 1'b0;
	err_before = errors;
	if (cpu_ack_o !== 1'b0 || bus_cyc_o !== 1'b0 || cpu_busy_o !== 1'b0)
		report_error("ack, bus cycle or busy not low after reset");
	close_test("reset", err_before);
	for (int i = 0; i < ROWS; i++)
		run_row(i);
	run_burst();
	run_duplicate();
	$display("%0d tests passed, %0d tests failed, %0d errors", passed, failed, errors);
	if (errors == 0 && failed == 0)
		$display("Simulation finished: PASS");
	else
		$display("Simulation finished: FAIL");
	$finish;
end

endmodule

// ==== list.f ====
+incdir+verilog
verilog/dcc_pkg.sv
verilog/dcc_ifs.sv
verilog/dcc_req_queue.sv
verilog/dcc_splitter.sv
verilog/dcc_bus_issue.sv
verilog/dcc_resp_collect.sv
verilog/dcc_top.sv
sim/dcc_mem_model.sv
sim/tb_dcc.sv

// ==== Bender.yml ====
package:
  name: dcc

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/dcc_pkg.sv
      - verilog/dcc_ifs.sv
      - verilog/dcc_req_queue.sv
      - verilog/dcc_splitter.sv
      - verilog/dcc_bus_issue.sv
      - verilog/dcc_resp_collect.sv
      - verilog/dcc_top.sv
  - target: simulation
    files:
      - sim/dcc_mem_model.sv
      - sim/tb_dcc.sv
